//--- src/la_pkg.sv
package la_pkg;

   // Fixed channel count of the analyzer
   localparam int N_CHANNELS = 9;

   // Widest capture word supported by the fallback readout pattern
   localparam int MAX_DEPTH = 1024;

   // Trigger sources, other codes never fire
   typedef enum logic [2:0] {
      TRIG_EXTERNAL = 3'd0,
      TRIG_DEBUG    = 3'd1,
      TRIG_MANUAL   = 3'd2
   } la_trig_src_t;

   // Capture groups, other codes select the pattern
   typedef enum logic [2:0] {
      GROUP_USER_IO = 3'd0,
      GROUP_DEBUG   = 3'd1,
      GROUP_TRACE   = 3'd2
   } la_group_t;

   // Host register map
   typedef enum logic [7:0] {
      REG_CAPTURE_GROUP  = 8'd0,
      REG_STATUS         = 8'd1,
      REG_TRIGGER_SOURCE = 8'd2,
      REG_READ_SELECT    = 8'd3,
      REG_CAPTURE_DEPTH  = 8'd4,
      REG_MANUAL_CAPTURE = 8'd5
   } la_reg_addr_t;

   // Even channels high, odd channels low
   localparam logic [N_CHANNELS-1:0] PATTERN_BITS = 9'b1_0101_0101;

   // Returned for a read select past the last channel, sliced to the capture depth
   localparam logic [MAX_DEPTH-1:0] BAD_SELECT_PATTERN = ~MAX_DEPTH'(2'b11);

endpackage

//--- src/la_regs.sv
`timescale 1ns/1ns

module la_regs import la_pkg::*; #(
   parameter int CAPTURE_DEPTH = 32,
   parameter int BYTECNT_WIDTH = 7
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  logic [7:0]               reg_address,
   input  logic [BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic [7:0]               reg_datai,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  logic                     capturing,
   input  logic [7:0]               read_byte,
   output logic [7:0]               reg_datao,
   output la_trig_src_t             trigger_source,
   output la_group_t                capture_group,
   output logic [3:0]               read_select,
   output logic                     manual_capture
);

   // Depth as a plain word so the host can fetch it bytewise
   localparam logic [31:0] DEPTH_WORD = CAPTURE_DEPTH;

   la_reg_addr_t addr;
   logic [7:0]   depth_byte;

   assign addr = la_reg_addr_t'(reg_address);

   // Shifting keeps out-of-range byte counts at zero
   assign depth_byte = 8'(DEPTH_WORD >> {reg_bytecnt, 3'b000});

   // Control registers, each write trimmed to its own width
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trigger_source <= TRIG_EXTERNAL;
         capture_group  <= GROUP_USER_IO;
         read_select    <= 4'd0;
         manual_capture <= 1'b0;
      end else if (reg_write) begin
         case (addr)
            REG_TRIGGER_SOURCE: trigger_source <= la_trig_src_t'(reg_datai[2:0]);
            REG_CAPTURE_GROUP:  capture_group  <= la_group_t'(reg_datai[2:0]);
            REG_READ_SELECT:    read_select    <= reg_datai[3:0];
            REG_MANUAL_CAPTURE: manual_capture <= reg_datai[0];
            default: ; // Status and depth are read-only
         endcase
      end
   end

   // Read data, zero whenever the host is not reading
   always_comb begin
      reg_datao = 8'd0;
      if (reg_read) begin
         case (addr)
            REG_CAPTURE_GROUP:  reg_datao = {5'd0, capture_group};
            REG_STATUS:         reg_datao = {7'd0, capturing};
            REG_TRIGGER_SOURCE: reg_datao = {5'd0, trigger_source};
            REG_READ_SELECT:    reg_datao = read_byte;
            REG_CAPTURE_DEPTH:  reg_datao = depth_byte;
            REG_MANUAL_CAPTURE: reg_datao = {7'd0, manual_capture};
            default:            reg_datao = 8'd0;
         endcase
      end
   end

endmodule

//--- src/la_trigger.sv
`timescale 1ns/1ns

module la_trigger import la_pkg::*; #(
   parameter int CAPTURE_DEPTH = 32
) (
   input  logic         observer_clk,
   input  logic         reset,
   input  la_trig_src_t trigger_source,
   input  logic         ext_trigger,
   input  logic         debug_trigger,
   input  logic         manual_capture,
   output logic         capture_go,
   output logic         capturing
);

   localparam int CNT_WIDTH = $clog2(CAPTURE_DEPTH);

   logic                 trig_async;
   logic [1:0]           trig_sync;   // Two-stage synchronizer
   logic                 trig_r;
   logic                 trig_r2;
   logic [CNT_WIDTH-1:0] sample_count;

   always_comb begin
      case (trigger_source)
         TRIG_EXTERNAL: trig_async = ext_trigger;
         TRIG_DEBUG:    trig_async = debug_trigger;
         TRIG_MANUAL:   trig_async = manual_capture;
         default:       trig_async = 1'b0; // No trigger
      endcase
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_sync <= 2'b00;
         trig_r    <= 1'b0;
         trig_r2   <= 1'b0;
      end else begin
         {trig_r2, trig_r, trig_sync} <= {trig_r, trig_sync, trig_async};
      end
   end

   assign capture_go = trig_r & ~trig_r2; // Rising edge only

   // A fresh trigger restarts the capture window
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sample_count <= '0;
         capturing    <= 1'b0;
      end else if (capture_go) begin
         sample_count <= '0;
         capturing    <= 1'b1;
      end else if (capturing) begin
         if (sample_count < CNT_WIDTH'(CAPTURE_DEPTH - 1))
            sample_count <= sample_count + 1'b1;
         else
            capturing <= 1'b0; // Window done
      end
   end

endmodule

//--- src/la_source_select.sv
`timescale 1ns/1ns

module la_source_select import la_pkg::*; (
   input  logic                  observer_clk,
   input  la_group_t             capture_group,
   input  logic [7:0]            user_io,
   input  logic                  user_io_clk,
   input  logic [8:0]            debug_bus,
   input  logic [7:0]            trace_data,
   input  logic                  trace_clk,
   output logic [N_CHANNELS-1:0] sample_bits
);

   // One register stage between the probes and the channels.
   // In the real groups the last channel carries that group's clock.
   always_ff @(posedge observer_clk) begin
      case (capture_group)
         GROUP_USER_IO: sample_bits <= {user_io_clk, user_io};
         GROUP_DEBUG:   sample_bits <= debug_bus;
         GROUP_TRACE:   sample_bits <= {trace_clk, trace_data};
         default:       sample_bits <= PATTERN_BITS; // Unused group
      endcase
   end

endmodule

//--- src/la_channel.sv
`timescale 1ns/1ns

module la_channel #(
   parameter int CAPTURE_DEPTH = 32
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  logic                     capture_go,
   input  logic                     capturing,
   input  logic                     sample,
   output logic [CAPTURE_DEPTH-1:0] channel_data
);

   // New samples enter at the top, so the oldest ends up in bit 0
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         channel_data <= '0;
      end else if (capture_go) begin
         channel_data <= {sample, {(CAPTURE_DEPTH-1){1'b0}}}; // First sample
      end else if (capturing) begin
         channel_data <= {sample, channel_data[CAPTURE_DEPTH-1:1]};
      end
   end

endmodule

//--- src/la_readout.sv
`timescale 1ns/1ns

module la_readout import la_pkg::*; #(
   parameter int CAPTURE_DEPTH = 32,
   parameter int BYTECNT_WIDTH = 7
) (
   input  logic                     observer_clk,
   input  logic [3:0]               read_select,
   input  logic [BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic [CAPTURE_DEPTH-1:0] channel_data [N_CHANNELS],
   output logic [7:0]               read_byte
);

   logic [CAPTURE_DEPTH-1:0] read_word;

   // Selected channel, or a recognizable filler past the last one
   always_ff @(posedge observer_clk) begin
      if (read_select < 4'(N_CHANNELS))
         read_word <= channel_data[read_select];
      else
         read_word <= BAD_SELECT_PATTERN[CAPTURE_DEPTH-1:0];
   end

   // Byte 0 holds the oldest samples
   assign read_byte = 8'(read_word >> {reg_bytecnt, 3'b000});

endmodule

//--- src/la_top.sv
`timescale 1ns/1ns

module la_top import la_pkg::*; #(
   parameter int CAPTURE_DEPTH = 32,
   parameter int BYTECNT_WIDTH = 7
) (
   input  logic                     observer_clk,
   input  logic                     reset,
   // Host register port
   input  logic [7:0]               reg_address,
   input  logic [BYTECNT_WIDTH-1:0] reg_bytecnt,
   input  logic [7:0]               reg_datai,
   output logic [7:0]               reg_datao,
   input  logic                     reg_read,
   input  logic                     reg_write,
   // Probes, all asynchronous
   input  logic [7:0]               user_io,
   input  logic                     user_io_clk,
   input  logic [8:0]               debug_bus,
   input  logic [7:0]               trace_data,
   input  logic                     trace_clk,
   input  logic                     ext_trigger
);

   la_trig_src_t             trigger_source;
   la_group_t                capture_group;
   logic [3:0]               read_select;
   logic                     manual_capture;
   logic                     capture_go;
   logic                     capturing;
   logic [N_CHANNELS-1:0]    sample_bits;
   logic [CAPTURE_DEPTH-1:0] channel_data [N_CHANNELS];
   logic [7:0]               read_byte;

   la_regs #(
      .CAPTURE_DEPTH  (CAPTURE_DEPTH),
      .BYTECNT_WIDTH  (BYTECNT_WIDTH)
   ) u_regs (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datai      (reg_datai),
      .reg_read       (reg_read),
      .reg_write      (reg_write),
      .capturing      (capturing),
      .read_byte      (read_byte),
      .reg_datao      (reg_datao),
      .trigger_source (trigger_source),
      .capture_group  (capture_group),
      .read_select    (read_select),
      .manual_capture (manual_capture)
   );

   la_trigger #(
      .CAPTURE_DEPTH  (CAPTURE_DEPTH)
   ) u_trigger (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .trigger_source (trigger_source),
      .ext_trigger    (ext_trigger),
      .debug_trigger  (debug_bus[0]), // Debug bit 0 doubles as a trigger
      .manual_capture (manual_capture),
      .capture_go     (capture_go),
      .capturing      (capturing)
   );

   la_source_select u_source_select (
      .observer_clk   (observer_clk),
      .capture_group  (capture_group),
      .user_io        (user_io),
      .user_io_clk    (user_io_clk),
      .debug_bus      (debug_bus),
      .trace_data     (trace_data),
      .trace_clk      (trace_clk),
      .sample_bits    (sample_bits)
   );

   for (genvar k = 0; k < N_CHANNELS; k++) begin : g_channel
      la_channel #(
         .CAPTURE_DEPTH (CAPTURE_DEPTH)
      ) u_channel (
         .observer_clk  (observer_clk),
         .reset         (reset),
         .capture_go    (capture_go),
         .capturing     (capturing),
         .sample        (sample_bits[k]),
         .channel_data  (channel_data[k])
      );
   end

   la_readout #(
      .CAPTURE_DEPTH  (CAPTURE_DEPTH),
      .BYTECNT_WIDTH  (BYTECNT_WIDTH)
   ) u_readout (
      .observer_clk   (observer_clk),
      .read_select    (read_select),
      .reg_bytecnt    (reg_bytecnt),
      .channel_data   (channel_data),
      .read_byte      (read_byte)
   );

endmodule

//--- testbench/la_clock_gen.sv
`timescale 1ns/1ns

module la_clock_gen #(
   parameter int HALF_PERIOD = 10
) (
   output logic observer_clk,
   output logic reset
);

   initial begin
      observer_clk = 1'b0;
      forever #HALF_PERIOD observer_clk = ~observer_clk;
   end

   // Held through the first two rising edges
   initial begin
      reset <= 1'b1;
      repeat (2) @(posedge observer_clk);
      reset <= 1'b0;
   end

endmodule

//--- testbench/la_properties.sv
`timescale 1ns/1ns

module la_properties (
   input logic       observer_clk,
   input logic       reset,
   input logic       reg_read,
   input logic [7:0] reg_datao,
   input logic       capture_go,
   input logic       capturing
);

   int failures = 0; // Failed properties so far

   // No capture survives a reset
   capturing_clear_after_reset: assert property (
      @(posedge observer_clk) reset |=> !capturing
   ) else begin
      failures++;
      $error("capturing is high in the cycle after reset");
   end

   // Read bus stays quiet between reads
   datao_zero_when_idle: assert property (
      @(posedge observer_clk) disable iff (reset)
      !reg_read |-> reg_datao == 8'd0
   ) else begin
      failures++;
      $error("reg_datao is not zero while reg_read is low");
   end

   capturing_follows_go: assert property (
      @(posedge observer_clk) disable iff (reset)
      $rose(capturing) |-> $past(capture_go)
   ) else begin
      failures++;
      $error("capturing rose without capture_go in the cycle before");
   end

endmodule

bind la_top la_properties u_properties (
   .observer_clk (observer_clk),
   .reset        (reset),
   .reg_read     (reg_read),
   .reg_datao    (reg_datao),
   .capture_go   (capture_go),
   .capturing    (capturing)
);

//--- testbench/la_tb.sv
`timescale 1ns/1ns

module la_tb import la_pkg::*;;

   localparam int DEPTH         = 32;
   localparam int BYTECNT_WIDTH = 7;
   localparam int STATUS_POLLS  = 100;
   localparam int RESET_CYCLES  = 20;

   // All ones except the two lowest bits
   localparam logic [DEPTH-1:0] BAD_WORD = {{(DEPTH-2){1'b1}}, 2'b00};

   logic                     observer_clk;
   logic                     reset;
   logic [7:0]               reg_address;
   logic [BYTECNT_WIDTH-1:0] reg_bytecnt;
   logic [7:0]               reg_datai;
   logic [7:0]               reg_datao;
   logic                     reg_read;
   logic                     reg_write;
   logic [7:0]               user_io;
   logic                     user_io_clk;
   logic [8:0]               debug_bus;
   logic [7:0]               trace_data;
   logic                     trace_clk;
   logic                     ext_trigger;

   integer seed = 32'hf347;
   int     checks = 0;
   int     errors = 0;
   int     timeouts = 0;

   la_clock_gen u_clock_gen (
      .observer_clk (observer_clk),
      .reset        (reset)
   );

   la_top #(
      .CAPTURE_DEPTH (DEPTH),
      .BYTECNT_WIDTH (BYTECNT_WIDTH)
   ) u_la_top (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .reg_address   (reg_address),
      .reg_bytecnt   (reg_bytecnt),
      .reg_datai     (reg_datai),
      .reg_datao     (reg_datao),
      .reg_read      (reg_read),
      .reg_write     (reg_write),
      .user_io       (user_io),
      .user_io_clk   (user_io_clk),
      .debug_bus     (debug_bus),
      .trace_data    (trace_data),
      .trace_clk     (trace_clk),
      .ext_trigger   (ext_trigger)
   );

   task automatic check_equal(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge observer_clk);
      reg_write   <= 1'b0;
   endtask

   // Read data is sampled mid-cycle between the edges
   task automatic read_reg(input logic [7:0] addr, input logic [BYTECNT_WIDTH-1:0] bytecnt,
                           output logic [7:0] data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bytecnt;
      reg_read    <= 1'b1;
      @(negedge observer_clk);
      data = reg_datao;
      @(posedge observer_clk);
      reg_read    <= 1'b0;
   endtask

   task automatic wait_status(input logic [7:0] level, input string what);
      logic [7:0] status;
      int         polls;
      polls = 0;
      read_reg(REG_STATUS, '0, status);
      while (status != level && polls < STATUS_POLLS) begin
         read_reg(REG_STATUS, '0, status);
         polls++;
      end
      if (status != level) begin
         timeouts++;
         $display("timeout: status never reached %0d during %s", level, what);
      end
   endtask

   task automatic read_channel(input int k, output logic [DEPTH-1:0] word);
      logic [7:0] b;
      int         i;
      write_reg(REG_READ_SELECT, 8'(k));
      repeat (2) @(posedge observer_clk); // Select register plus readout stage
      for (i = 0; i < DEPTH / 8; i++) begin
         read_reg(REG_READ_SELECT, BYTECNT_WIDTH'(i), b);
         word[8*i +: 8] = b;
      end
   endtask

   task automatic check_channel(input int k, input logic [DEPTH-1:0] expected,
                                input string name);
      logic [DEPTH-1:0] word;
      int               i;
      read_channel(k, word);
      for (i = 0; i < DEPTH / 8; i++)
         check_equal($sformatf("%s_ch%0d_byte%0d", name, k, i), expected[8*i +: 8],
                     word[8*i +: 8]);
   endtask

   // Oldest samples sit low so a rising step leaves ones only at the top
   function automatic logic zeros_then_ones(input logic [DEPTH-1:0] w);
      logic [DEPTH-1:0] low_ones;
      low_ones = ~w;
      return (w != '0) && (low_ones != '0) && ((low_ones & (low_ones + DEPTH'(1))) == '0);
   endfunction

   initial begin
      logic [7:0]       value;
      logic [7:0]       data;
      logic [8:0]       probe;
      logic [DEPTH-1:0] word;
      int               count;
      int               i;
      int               k;
      int               prop_failures;

      reg_address <= '0;
      reg_bytecnt <= '0;
      reg_datai   <= '0;
      reg_read    <= 1'b0;
      reg_write   <= 1'b0;
      user_io     <= '0;
      user_io_clk <= 1'b0;
      debug_bus   <= '0;
      trace_data  <= '0;
      trace_clk   <= 1'b0;
      ext_trigger <= 1'b0;

      count = 0;
      @(posedge observer_clk);
      while (reset && count < RESET_CYCLES) begin
         @(posedge observer_clk);
         count++;
      end
      if (reset) begin
         timeouts++;
         $display("timeout: reset was never released");
      end

      // Reset values
      read_reg(REG_CAPTURE_GROUP, '0, data);
      check_equal("reset_group", 8'd0, data);
      read_reg(REG_TRIGGER_SOURCE, '0, data);
      check_equal("reset_trigger", 8'd0, data);
      read_reg(REG_READ_SELECT, '0, data);
      check_equal("reset_read_select", 8'd0, data);
      read_reg(REG_STATUS, '0, data);
      check_equal("reset_status", 8'd0, data);
      for (i = 0; i < 4; i++) begin
         read_reg(REG_CAPTURE_DEPTH, BYTECNT_WIDTH'(i), data);
         check_equal($sformatf("depth_byte%0d", i), 8'(DEPTH >> (8 * i)), data);
      end

      // Register round trip while the channels are still empty
      for (i = 0; i < 8; i++) begin
         value = 8'($random(seed));
         write_reg(REG_CAPTURE_GROUP, value);
         read_reg(REG_CAPTURE_GROUP, '0, data);
         check_equal("roundtrip_group", {5'd0, value[2:0]}, data);
         write_reg(REG_TRIGGER_SOURCE, value);
         read_reg(REG_TRIGGER_SOURCE, '0, data);
         check_equal("roundtrip_trigger", {5'd0, value[2:0]}, data);
         write_reg(REG_READ_SELECT, value);
         repeat (2) @(posedge observer_clk);
         read_reg(REG_READ_SELECT, '0, data);
         check_equal("roundtrip_read_select", (value[3:0] < 4'd9) ? 8'h00 : BAD_WORD[7:0], data);
         read_reg({1'b1, 7'($random(seed))}, '0, data); // Past the register map
         check_equal("unknown_address", 8'd0, data);
      end

      // Pattern capture from the manual trigger
      write_reg(REG_CAPTURE_GROUP, 8'd5);
      write_reg(REG_TRIGGER_SOURCE, 8'd2);
      write_reg(REG_MANUAL_CAPTURE, 8'd1);
      wait_status(8'd1, "pattern capture start");
      wait_status(8'd0, "pattern capture end");
      write_reg(REG_MANUAL_CAPTURE, 8'd0);
      for (k = 0; k < N_CHANNELS; k++)
         check_channel(k, (k % 2 == 0) ? {DEPTH{1'b1}} : {DEPTH{1'b0}}, "pattern");

      // Constant user I/O with the external trigger
      probe = 9'($random(seed));
      @(posedge observer_clk);
      user_io     <= probe[7:0];
      user_io_clk <= probe[8];
      write_reg(REG_CAPTURE_GROUP, 8'd0);
      write_reg(REG_TRIGGER_SOURCE, 8'd0);
      @(posedge observer_clk);
      ext_trigger <= 1'b1;
      wait_status(8'd1, "user I/O capture start");
      wait_status(8'd0, "user I/O capture end");
      @(posedge observer_clk);
      ext_trigger <= 1'b0;
      for (k = 0; k < N_CHANNELS; k++)
         check_channel(k, {DEPTH{probe[k]}}, "user_io");

      // Step on trace bit 0 triggered by debug bit 0
      write_reg(REG_CAPTURE_GROUP, 8'd2);
      write_reg(REG_TRIGGER_SOURCE, 8'd1);
      @(posedge observer_clk);
      debug_bus <= 9'h001;
      wait_status(8'd1, "trace capture start");
      repeat (8) @(posedge observer_clk);
      trace_data <= 8'h01;
      wait_status(8'd0, "trace capture end");
      @(posedge observer_clk);
      debug_bus  <= '0;
      trace_data <= '0;
      read_channel(0, word);
      checks++;
      assert (zeros_then_ones(word)) else begin
         errors++;
         $display("error step_trace: expected zeros then ones, actual %h", word);
      end

      // Select past the last channel
      check_channel(9, BAD_WORD, "bad_select");

      @(negedge observer_clk);
      prop_failures = u_la_top.u_properties.failures;
      $display("checks %0d, errors %0d, timeouts %0d, property failures %0d", checks, errors,
               timeouts, prop_failures);
      if (errors == 0 && timeouts == 0 && prop_failures == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- project.f
src/la_pkg.sv
src/la_regs.sv
src/la_trigger.sv
src/la_source_select.sv
src/la_channel.sv
src/la_readout.sv
src/la_top.sv
testbench/la_clock_gen.sv
testbench/la_properties.sv
testbench/la_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the logic analyzer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module la_tb -f project.f -o la_sim
./obj_dir/la_sim 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
exit 0
